// ==== design/frame_buffer.sv ====
module frame_buffer (
    input  logic               clk_16bd,
    input  logic               rst,
    input  uart_pkg::mem_req_t wr_req,
    input  uart_pkg::mem_req_t rd_req,
    output logic               wr_grant,
    output logic               rd_grant,
    output uart_pkg::frame_t   rd_data
);

    uart_pkg::frame_t mem [uart_pkg::BUF_DEPTH];

    // Fixed priority. The writer always wins a shared cycle.
    assign wr_grant = wr_req.valid;
    assign rd_grant = rd_req.valid && !wr_req.valid;

    always_ff @(posedge clk_16bd) begin
        if (wr_grant) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_grant) begin
            rd_data <= mem[rd_req.addr]; // Valid in the cycle after the grant.
        end
    end

endmodule

// ==== design/rx_store.sv ====
module rx_store (
    input  logic                      clk_16bd,
    input  logic                      rst,
    input  uart_pkg::frame_t          frame,
    input  logic                      frame_valid,
    input  logic [uart_pkg::PTR_W-1:0] rd_ptr,
    output uart_pkg::mem_req_t        wr_req,
    input  logic                      wr_grant,
    output logic [uart_pkg::PTR_W-1:0] wr_ptr,
    output logic                      overflow
);

    logic full;

    // Same slot but opposite lap means every entry is taken.
    assign full = (wr_ptr[uart_pkg::PTR_W-1] != rd_ptr[uart_pkg::PTR_W-1]) &&
                  (wr_ptr[uart_pkg::PTR_W-2:0] == rd_ptr[uart_pkg::PTR_W-2:0]);

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            wr_req   <= '0;
            wr_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_req.valid && wr_grant) begin
                wr_req.valid <= 1'b0;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            if (frame_valid) begin
                if (full) begin
                    overflow <= 1'b1; // The new frame is discarded.
                end else begin
                    wr_req.valid <= 1'b1;
                    wr_req.addr  <= wr_ptr[uart_pkg::PTR_W-2:0];
                    wr_req.data  <= frame;
                end
            end
        end
    end

endmodule

// ==== design/tx_fetch.sv ====
module tx_fetch (
    input  logic                      clk_16bd,
    input  logic                      rst,
    input  logic                      cts,
    input  logic [uart_pkg::PTR_W-1:0] wr_ptr,
    input  logic                      busy,
    output uart_pkg::mem_req_t        rd_req,
    input  logic                      rd_grant,
    input  uart_pkg::frame_t          rd_data,
    output logic [uart_pkg::PTR_W-1:0] rd_ptr,
    output uart_pkg::frame_t          frame,
    output logic                      start
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_deliver
    } fetch_state_t;

    fetch_state_t state;
    logic         not_empty;

    assign not_empty = (rd_ptr != wr_ptr);
    assign frame     = rd_data; // Read data lands together with start.

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            rd_req <= '0;
            rd_ptr <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (not_empty && cts && !busy) begin
                        rd_req.valid <= 1'b1;
                        rd_req.addr  <= rd_ptr[uart_pkg::PTR_W-2:0];
                        rd_req.data  <= '0;
                        state        <= st_request;
                    end
                end
                st_request: begin
                    if (rd_grant) begin
                        rd_req.valid <= 1'b0;
                        rd_ptr       <= rd_ptr + 1'b1;
                        start        <= 1'b1;
                        state        <= st_deliver;
                    end
                end
                st_deliver: begin
                    if (busy) begin
                        state <= st_idle; // Idle then waits for busy to drop.
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== design/uart_echo_top.sv ====
module uart_echo_top (
    input  logic                clk_16bd,
    input  logic                rst,
    input  logic                rx,
    input  uart_pkg::line_cfg_t cfg,
    input  logic                cts,
    output logic                tx,
    output logic                frame_error,
    output logic                overflow
);

    uart_pkg::frame_t               rx_frame;
    logic                           rx_frame_valid;
    uart_pkg::mem_req_t             wr_req;
    uart_pkg::mem_req_t             rd_req;
    logic                           wr_grant;
    logic                           rd_grant;
    uart_pkg::frame_t               rd_data;
    logic [uart_pkg::PTR_W-1:0]     wr_ptr;
    logic [uart_pkg::PTR_W-1:0]     rd_ptr;
    uart_pkg::frame_t               tx_frame;
    logic                           tx_start;
    logic                           tx_busy;

    uart_rx u_rx (
        .clk_16bd    (clk_16bd),
        .rst         (rst),
        .rx          (rx),
        .cfg         (cfg),
        .frame       (rx_frame),
        .frame_valid (rx_frame_valid),
        .frame_error (frame_error)
    );

    rx_store u_store (
        .clk_16bd    (clk_16bd),
        .rst         (rst),
        .frame       (rx_frame),
        .frame_valid (rx_frame_valid),
        .rd_ptr      (rd_ptr),
        .wr_req      (wr_req),
        .wr_grant    (wr_grant),
        .wr_ptr      (wr_ptr),
        .overflow    (overflow)
    );

    frame_buffer u_buffer (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .wr_grant (wr_grant),
        .rd_grant (rd_grant),
        .rd_data  (rd_data)
    );

    tx_fetch u_fetch (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .cts      (cts),
        .wr_ptr   (wr_ptr),
        .busy     (tx_busy),
        .rd_req   (rd_req),
        .rd_grant (rd_grant),
        .rd_data  (rd_data),
        .rd_ptr   (rd_ptr),
        .frame    (tx_frame),
        .start    (tx_start)
    );

    uart_tx u_tx (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .cfg      (cfg),
        .frame    (tx_frame),
        .start    (tx_start),
        .tx       (tx),
        .busy     (tx_busy)
    );

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

    localparam int OVERSAMPLE   = 16; // Clocks per bit cell.
    localparam int SAMPLE_POINT = 7;  // Oversample count where a bit is taken.
    localparam int BUF_DEPTH    = 16;
    localparam int PTR_W        = 5;  // One wrap bit above the buffer address.

    // Line format shared by the receiver and the transmitter.
    typedef struct packed {
        logic       parity_en;
        logic       parity_odd;
        logic       two_stop;
        logic [3:0] frame_length; // Legal range is 5 to 9.
    } line_cfg_t;

    // Data sits in the low frame_length bits, the rest stays zero.
    typedef logic [8:0] frame_t;

    typedef struct packed {
        logic             valid;
        logic [PTR_W-2:0] addr;
        frame_t           data; // Only meaningful for writes.
    } mem_req_t;

endpackage

// ==== design/uart_rx.sv ====
module uart_rx (
    input  logic                clk_16bd,
    input  logic                rst,
    input  logic                rx,
    input  uart_pkg::line_cfg_t cfg,
    output uart_pkg::frame_t    frame,
    output logic                frame_valid,
    output logic                frame_error
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_drop
    } rx_state_t;

    rx_state_t  state;
    logic [3:0] os_cnt;
    logic [3:0] bit_cnt;
    logic       stop_cnt;
    logic       parity_bad;
    logic       stop_bad;
    logic       sample;
    logic       cell_end;
    logic       last_bit;

    assign sample   = (os_cnt == 4'(uart_pkg::SAMPLE_POINT));
    assign cell_end = (os_cnt == 4'(uart_pkg::OVERSAMPLE - 1));
    assign last_bit = (bit_cnt == cfg.frame_length - 4'd1);

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            os_cnt      <= 4'd0;
            bit_cnt     <= 4'd0;
            stop_cnt    <= 1'b0;
            parity_bad  <= 1'b0;
            stop_bad    <= 1'b0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
            os_cnt      <= os_cnt + 4'd1;
            case (state)
                st_idle: begin
                    os_cnt     <= 4'd1; // The edge cycle counts as sample zero.
                    bit_cnt    <= 4'd0;
                    stop_cnt   <= 1'b0;
                    parity_bad <= 1'b0;
                    stop_bad   <= 1'b0;
                    if (!rx) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cell_end) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (cell_end) begin
                        if (last_bit) begin
                            state <= cfg.parity_en ? st_parity : st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                st_parity: begin
                    if (sample) begin
                        parity_bad <= ((^frame) ^ rx) != cfg.parity_odd;
                    end
                    if (cell_end) begin
                        state <= st_stop;
                    end
                end
                st_stop: begin
                    if (sample && !rx) begin
                        stop_bad <= 1'b1;
                    end
                    if (cell_end) begin
                        if (cfg.two_stop && !stop_cnt) begin
                            stop_cnt <= 1'b1;
                        end else if (parity_bad || stop_bad) begin
                            frame_error <= 1'b1;
                            state       <= st_drop;
                        end else begin
                            frame_valid <= 1'b1;
                            state       <= st_idle;
                        end
                    end
                end
                st_drop: begin
                    if (rx) begin
                        state <= st_idle; // Wait for the line to go back to mark.
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Frame assembly. Each sampled one is set at its bit position.
    always_ff @(posedge clk_16bd) begin
        if (state == st_start) begin
            frame <= '0;
        end else if (state == st_data && sample && rx) begin
            frame <= frame | (uart_pkg::frame_t'(1) << bit_cnt);
        end
    end

endmodule

// ==== design/uart_tx.sv ====
module uart_tx (
    input  logic                clk_16bd,
    input  logic                rst,
    input  uart_pkg::line_cfg_t cfg,
    input  uart_pkg::frame_t    frame,
    input  logic                start,
    output logic                tx,
    output logic                busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } tx_state_t;

    tx_state_t           state;
    logic [3:0]          os_cnt;
    logic [3:0]          bit_cnt;
    logic                stop_cnt;
    logic                cell_end;
    uart_pkg::frame_t    shift;
    uart_pkg::line_cfg_t cfg_q;
    logic                parity_bit;

    assign cell_end = (os_cnt == 4'(uart_pkg::OVERSAMPLE - 1));
    assign busy     = (state != st_idle);

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            tx       <= 1'b1;
            os_cnt   <= 4'd0;
            bit_cnt  <= 4'd0;
            stop_cnt <= 1'b0;
        end else if (state == st_idle) begin
            os_cnt <= 4'd0;
            if (start) begin
                state <= st_start;
                tx    <= 1'b0;
            end
        end else begin
            os_cnt <= os_cnt + 4'd1;
            if (cell_end) begin
                case (state)
                    st_start: begin
                        state   <= st_data;
                        tx      <= shift[0];
                        bit_cnt <= 4'd0;
                    end
                    st_data: begin
                        if (bit_cnt == cfg_q.frame_length - 4'd1) begin
                            state    <= cfg_q.parity_en ? st_parity : st_stop;
                            tx       <= cfg_q.parity_en ? parity_bit : 1'b1;
                            stop_cnt <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                            tx      <= shift[0];
                        end
                    end
                    st_parity: begin
                        state    <= st_stop;
                        tx       <= 1'b1;
                        stop_cnt <= 1'b0;
                    end
                    default: begin
                        if (cfg_q.two_stop && !stop_cnt) begin
                            stop_cnt <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    // Frame and format are held for the whole transfer.
    always_ff @(posedge clk_16bd) begin
        if (state == st_idle && start) begin
            shift      <= frame;
            cfg_q      <= cfg;
            parity_bit <= (^frame) ^ cfg.parity_odd; // Upper frame bits are zero.
        end else if (cell_end && (state == st_start || state == st_data)) begin
            shift <= shift >> 1;
        end
    end

endmodule

// ==== dv/uart_echo_tb.sv ====
module uart_echo_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int FRAMES_SENT   = 47; // 10 + 15 + 2 + 2 + 18 frames over all tests.
    localparam int LONGEST_CELLS = 13;
    localparam int CYCLE_LIMIT   =
        FRAMES_SENT * uart_pkg::OVERSAMPLE * LONGEST_CELLS * 2 + 2000;

    logic                clk_16bd;
    logic                rst;
    logic                rx;
    uart_pkg::line_cfg_t cfg;
    logic                cts;
    logic                tx;
    logic                frame_error;
    logic                overflow;

    uart_pkg::frame_t exp_q[$]; // Good frames waiting to come back on tx.
    int errors = 0;
    int test_errors_base = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int error_pulses = 0;
    int overflow_pulses = 0;
    int frames_seen = 0;
    int cycle_cnt = 0;
    bit mon_busy = 1'b0;
    bit tx_hold = 1'b0;

    uart_echo_top dut0 (
        .clk_16bd    (clk_16bd),
        .rst         (rst),
        .rx          (rx),
        .cfg         (cfg),
        .cts         (cts),
        .tx          (tx),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    initial begin
        clk_16bd = 1'b0;
        forever #2 clk_16bd = ~clk_16bd;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_16bd);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the echo traffic never finished.", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input uart_pkg::frame_t expected,
                               input uart_pkg::frame_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic uart_pkg::frame_t random_frame(input int len);
        return uart_pkg::frame_t'($urandom & ((32'd1 << len) - 32'd1));
    endfunction

    task automatic set_format(input logic par_en, input logic par_odd, input logic two_stop,
                              input int len);
        @(negedge clk_16bd);
        cfg.parity_en    = par_en;
        cfg.parity_odd   = par_odd;
        cfg.two_stop     = two_stop;
        cfg.frame_length = 4'(len);
    endtask

    task automatic drive_bit(input logic value);
        @(negedge clk_16bd);
        rx = value;
        repeat (uart_pkg::OVERSAMPLE - 1) @(negedge clk_16bd);
    endtask

    task automatic send_frame(input uart_pkg::frame_t data, input logic bad_parity,
                              input logic bad_stop, input logic keep);
        logic par;
        int   i;
        par = (^data) ^ cfg.parity_odd ^ bad_parity; // Even count of ones unless odd is set.
        if (keep && !bad_parity && !bad_stop) begin
            exp_q.push_back(data);
        end
        drive_bit(1'b0);
        for (i = 0; i < int'(cfg.frame_length); i++) begin
            drive_bit(data[i]);
        end
        if (cfg.parity_en) begin
            drive_bit(par);
        end
        drive_bit(!bad_stop);
        if (cfg.two_stop) begin
            drive_bit(1'b1);
        end
        drive_bit(1'b1); // One idle cell between frames.
    endtask

    // Entered in the cycle the line falls, so each bit is taken at count 7.
    task automatic decode_tx_frame(output uart_pkg::frame_t data, output logic par,
                                   output logic stop);
        int i;
        data = '0;
        par  = 1'b0;
        repeat (uart_pkg::SAMPLE_POINT) @(negedge clk_16bd);
        for (i = 0; i < int'(cfg.frame_length); i++) begin
            repeat (uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
            data[i] = tx;
        end
        if (cfg.parity_en) begin
            repeat (uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
            par = tx;
        end
        repeat (uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
        stop = tx;
        if (cfg.two_stop) begin
            repeat (uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
            stop = stop & tx;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || mon_busy) begin
            @(negedge clk_16bd);
        end
        repeat (2 * uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
    endtask

    task automatic echo_one(input logic par_en, input logic par_odd, input logic two_stop,
                            input int len);
        set_format(par_en, par_odd, two_stop, len);
        send_frame(random_frame(len), 1'b0, 1'b0, 1'b1);
        wait_drain();
    endtask

    task automatic begin_test();
        test_errors_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors_base) begin
            $display("Test %0d, %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: failed with %0d errors", tests_run, name,
                     errors - test_errors_base);
        end
    endtask

    always @(negedge clk_16bd) begin
        if (!rst) begin
            if (frame_error) begin
                error_pulses++;
            end
            if (overflow) begin
                overflow_pulses++;
            end
            if (tx_hold) begin
                check_bit("tx", 1'b1, tx); // Nothing may leave while cts is low.
            end
        end
    end

    initial begin : tx_monitor
        uart_pkg::frame_t got;
        uart_pkg::frame_t expected;
        logic             par_bit;
        logic             stop_bit;
        forever begin
            @(negedge clk_16bd);
            if (!rst && tx === 1'b0) begin
                mon_busy = 1'b1;
                decode_tx_frame(got, par_bit, stop_bit);
                frames_seen++;
                if (cfg.parity_en) begin
                    // Ones over data and parity come out odd only in odd mode.
                    check_bit("tx parity", cfg.parity_odd,
                              $countones({got, par_bit}) % 2 == 1);
                end
                check_bit("tx stop", 1'b1, stop_bit);
                assert (exp_q.size() != 0) else begin
                    $display("Frame %h came out on tx at %0t with no frame pending.",
                             got, $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    check_frame("tx", expected, got);
                end
                mon_busy = 1'b0;
            end
        end
    end

    initial begin : test_sequence
        int seed_ret;
        int i;
        int len;
        int base_err;
        int base_ovf;
        int base_seen;
        rst              = 1'b1;
        rx               = 1'b1;
        cts              = 1'b1;
        cfg.parity_en    = 1'b1;
        cfg.parity_odd   = 1'b0;
        cfg.two_stop     = 1'b0;
        cfg.frame_length = 4'd8;
        seed_ret = $urandom(32'h537113b0);
        repeat (2) @(negedge clk_16bd);
        rst = 1'b0;

        begin_test();
        repeat (200) begin
            @(negedge clk_16bd);
            check_bit("tx", 1'b1, tx);
            check_bit("frame_error", 1'b0, frame_error);
            check_bit("overflow", 1'b0, overflow);
        end
        end_test("reset and idle line");

        begin_test();
        base_err  = error_pulses;
        base_ovf  = overflow_pulses;
        base_seen = frames_seen;
        for (i = 0; i < 10; i++) begin
            send_frame(random_frame(8), 1'b0, 1'b0, 1'b1);
        end
        wait_drain();
        check_count("echoed frames", 10, frames_seen - base_seen);
        check_count("frame_error pulses", 0, error_pulses - base_err);
        check_count("overflow pulses", 0, overflow_pulses - base_ovf);
        end_test("basic echo, 8 bits even parity");

        begin_test();
        base_err  = error_pulses;
        base_seen = frames_seen;
        for (len = 5; len <= 9; len++) begin
            echo_one(1'b1, 1'b1, 1'b0, len);
            echo_one(1'b0, 1'b0, 1'b0, len);
            echo_one(1'b1, 1'b0, 1'b1, len); // Longest frame at 9 bits.
        end
        check_count("echoed frames", 15, frames_seen - base_seen);
        check_count("frame_error pulses", 0, error_pulses - base_err);
        end_test("configuration sweep");

        begin_test();
        set_format(1'b1, 1'b0, 1'b0, 8);
        base_err  = error_pulses;
        base_seen = frames_seen;
        send_frame(random_frame(8), 1'b1, 1'b0, 1'b1);
        check_count("frame_error pulses", 1, error_pulses - base_err);
        send_frame(random_frame(8), 1'b0, 1'b0, 1'b1);
        wait_drain();
        check_count("echoed frames", 1, frames_seen - base_seen);
        check_count("frame_error pulses", 1, error_pulses - base_err);
        end_test("parity error");

        begin_test();
        base_err  = error_pulses;
        base_seen = frames_seen;
        send_frame(random_frame(8), 1'b0, 1'b1, 1'b1);
        check_count("frame_error pulses", 1, error_pulses - base_err);
        send_frame(random_frame(8), 1'b0, 1'b0, 1'b1);
        wait_drain();
        check_count("echoed frames", 1, frames_seen - base_seen);
        check_count("frame_error pulses", 1, error_pulses - base_err);
        end_test("stop bit error");

        begin_test();
        base_ovf  = overflow_pulses;
        base_seen = frames_seen;
        @(negedge clk_16bd);
        cts     = 1'b0;
        tx_hold = 1'b1;
        for (i = 0; i < 18; i++) begin
            send_frame(random_frame(8), 1'b0, 1'b0, i < uart_pkg::BUF_DEPTH);
        end
        repeat (4 * uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
        check_count("overflow pulses", 2, overflow_pulses - base_ovf);
        check_count("echoed frames", 0, frames_seen - base_seen);
        tx_hold = 1'b0;
        cts     = 1'b1;
        wait_drain();
        repeat (2 * LONGEST_CELLS * uart_pkg::OVERSAMPLE) @(negedge clk_16bd);
        check_count("echoed frames", 16, frames_seen - base_seen);
        check_count("overflow pulses", 2, overflow_pulses - base_ovf);
        end_test("back-pressure and overflow");

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module uart_echo_tb \
    -f src.f -o sim_echo || exit 1
result=$(./obj_dir/sim_echo)
echo "$result"
echo "$result" | grep -qx "PASS: all tests" && exit 0 || exit 1

// ==== src.f ====
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/rx_store.sv
design/tx_fetch.sv
design/frame_buffer.sv
design/uart_echo_top.sv
dv/uart_echo_tb.sv
